/* common/gameIo_settings.svh */
// Address map, VGA timing and sizes of the game I/O subsystem
// Included by the package, the RTL modules and the testbench
`ifndef GAME_IO_SETTINGS_SVH
`define GAME_IO_SETTINGS_SVH

// Register map, byte addresses on the APB side
`define ADDR_PLAYER1   12'h100
`define ADDR_PLAYER2   12'h104
`define ADDR_BUTTONS   12'h108
`define ADDR_GPIO_OUT  12'h10C
`define ADDR_LEDS      12'h110

`define RAM_WORDS      64       // Scratch memory at 0x000..0x0FC

`define BUTTON_COUNT   16       // Controller pins in use
`define GPIO_OUT_BITS  3        // General output pins
`define LED_BITS       16       // LED word width
`define SPRITE_SIZE    16       // Player square edge in pixels

// 640x480 horizontal timing, in pixel clocks
`define H_ACTIVE       640
`define H_FRONT        16
`define H_SYNC         96
`define H_BACK         48
`define H_TOTAL        (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// Vertical timing, in lines
`define V_ACTIVE       480
`define V_FRONT        10
`define V_SYNC         2
`define V_BACK         33
`define V_TOTAL        (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`endif

/* common/gamePkg.sv */
// Shared types of the game I/O subsystem
// Referenced by scoped names from the RTL and the testbench
`include "gameIo_settings.svh"

package gamePkg;

	typedef logic [31:0] word_t;                    // Bus data word
	typedef logic [11:0] busAddr_t;                 // Byte address
	typedef logic [`BUTTON_COUNT-1:0] buttons_t;    // One bit per button
	typedef logic [9:0] coordX_t;                   // Pixel column
	typedef logic [9:0] coordY_t;                   // Pixel line
	typedef logic [11:0] color4_t;                  // 4:4:4 color, red on top

	// Master side of APB
	typedef struct packed {
		logic     psel;
		logic     penable;
		logic     pwrite;
		busAddr_t paddr;
		word_t    pwdata;
	} apbReq_t;

	// Slave side of APB
	typedef struct packed {
		logic  pready;
		word_t prdata;
		logic  pslverr;
	} apbRsp_t;

	// Player register layout, 32 bits
	typedef struct packed {
		color4_t color;
		coordY_t y;
		coordX_t x;
	} playerDesc_t;

	// Raster position from the timing block
	typedef struct packed {
		coordX_t x;
		coordY_t y;
		logic    active;     // Inside 640x480
		logic    hSync;      // Active low
		logic    vSync;      // Active low
	} pixelPos_t;

	// Pins toward the DAC
	typedef struct packed {
		logic       hs;
		logic       vs;
		logic       blankN;
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} vgaOut_t;

endpackage

/* mmio/controllerSync.sv */
// Brings the controller pins into the clock domain and keeps sticky press flags
// The bridge clears the flags when the button register is read
`timescale 1ns/1ps
`include "gameIo_settings.svh"

module controllerSync (
	input  logic              clock,
	input  logic              rst,
	input  gamePkg::buttons_t pins,
	input  logic              clearSticky,
	output gamePkg::buttons_t level,
	output gamePkg::buttons_t sticky
);

	gamePkg::buttons_t syncFirst;     // Metastability stage
	gamePkg::buttons_t syncSecond;    // Settled level
	gamePkg::buttons_t levelPrev;     // Level one cycle back
	gamePkg::buttons_t pressEdge;
	gamePkg::buttons_t stickyReg;

	assign pressEdge = syncSecond & ~levelPrev;    // Rising edges only

	always_ff @(posedge clock) begin
		if (rst) begin
			syncFirst  <= '0;
			syncSecond <= '0;
			levelPrev  <= '0;
		end else begin
			syncFirst  <= pins;
			syncSecond <= syncFirst;
			levelPrev  <= syncSecond;
		end
	end

	// A new edge wins over a clear in the same cycle
	always_ff @(posedge clock) begin
		if (rst) begin
			stickyReg <= '0;
		end else if (clearSticky) begin
			stickyReg <= pressEdge;
		end else begin
			stickyReg <= stickyReg | pressEdge;
		end
	end

	assign level  = syncSecond;    // Two cycles after the pin
	assign sticky = stickyReg;     // Three cycles after a press

endmodule

/* mmio/mmioBridge.sv */
// APB slave for the scratch memory and the game register map
// Zero wait states; read data and errors are formed in the access phase
`timescale 1ns/1ps
`include "gameIo_settings.svh"

module mmioBridge (
	input  logic                      clock,
	input  logic                      rst,
	input  gamePkg::apbReq_t          apbIn,
	output gamePkg::apbRsp_t          apbOut,
	input  gamePkg::buttons_t         level,
	input  gamePkg::buttons_t         sticky,
	output logic                      clearSticky,
	output gamePkg::playerDesc_t      player1,
	output gamePkg::playerDesc_t      player2,
	output logic [`GPIO_OUT_BITS-1:0] gpioOutput,
	output logic [`LED_BITS-1:0]      leds
);

	localparam int RamAddrBits = $clog2(`RAM_WORDS);

	gamePkg::word_t mem [`RAM_WORDS];    // Scratch words
	gamePkg::word_t readData;

	logic [RamAddrBits-1:0] ramIndex;
	logic access;
	logic aligned;
	logic hitRam;
	logic hitP1;
	logic hitP2;
	logic hitButtons;
	logic hitGpio;
	logic hitLeds;
	logic mapped;
	logic badAccess;
	logic writeEn;

	assign access   = apbIn.psel & apbIn.penable;       // Second cycle of a transfer
	assign aligned  = (apbIn.paddr[1:0] == 2'b00);
	assign ramIndex = apbIn.paddr[RamAddrBits+1:2];     // Word index

	// Address decode
	assign hitRam     = aligned && (apbIn.paddr < (`RAM_WORDS * 4));
	assign hitP1      = (apbIn.paddr == `ADDR_PLAYER1);
	assign hitP2      = (apbIn.paddr == `ADDR_PLAYER2);
	assign hitButtons = (apbIn.paddr == `ADDR_BUTTONS);
	assign hitGpio    = (apbIn.paddr == `ADDR_GPIO_OUT);
	assign hitLeds    = (apbIn.paddr == `ADDR_LEDS);
	assign mapped     = hitRam | hitP1 | hitP2 | hitButtons | hitGpio | hitLeds;

	// Unmapped, misaligned, or a write to the read-only button word
	assign badAccess = access & (~mapped | ~aligned | (apbIn.pwrite & hitButtons));
	assign writeEn   = access & apbIn.pwrite & ~badAccess;

	assign clearSticky = access & ~apbIn.pwrite & hitButtons;    // Read clears flags

	always_ff @(posedge clock) begin
		if (writeEn && hitRam) begin
			mem[ramIndex] <= apbIn.pwdata;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			player1    <= '0;
			player2    <= '0;
			gpioOutput <= '0;
			leds       <= '0;
		end else if (writeEn) begin
			if (hitP1) player1 <= gamePkg::playerDesc_t'(apbIn.pwdata);
			if (hitP2) player2 <= gamePkg::playerDesc_t'(apbIn.pwdata);
			if (hitGpio) gpioOutput <= apbIn.pwdata[`GPIO_OUT_BITS-1:0];    // Low bits kept
			if (hitLeds) leds <= apbIn.pwdata[`LED_BITS-1:0];
		end
	end

	// Read mux, only driven in the access phase
	always_comb begin
		readData = '0;
		if (access && !badAccess) begin
			if (hitRam) begin
				readData = mem[ramIndex];
			end else if (hitP1) begin
				readData = gamePkg::word_t'(player1);
			end else if (hitP2) begin
				readData = gamePkg::word_t'(player2);
			end else if (hitButtons) begin
				readData = gamePkg::word_t'({sticky, level});    // Flags over levels
			end else if (hitGpio) begin
				readData = gamePkg::word_t'(gpioOutput);
			end else if (hitLeds) begin
				readData = gamePkg::word_t'(leds);
			end
		end
	end

	assign apbOut.pready  = 1'b1;    // Never stalls
	assign apbOut.prdata  = readData;
	assign apbOut.pslverr = badAccess;

endmodule

/* vga/vgaTiming.sv */
// Raster counters for 640x480 at one pixel per clock
// Gives the position, the active window and both syncs every cycle
`timescale 1ns/1ps
`include "gameIo_settings.svh"

module vgaTiming (
	input  logic               clock,
	input  logic               rst,
	output gamePkg::pixelPos_t pos
);

	localparam gamePkg::coordX_t HLast      = gamePkg::coordX_t'(`H_TOTAL - 1);
	localparam gamePkg::coordY_t VLast      = gamePkg::coordY_t'(`V_TOTAL - 1);
	localparam gamePkg::coordX_t HSyncStart = gamePkg::coordX_t'(`H_ACTIVE + `H_FRONT);
	localparam gamePkg::coordX_t HSyncEnd   = gamePkg::coordX_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
	localparam gamePkg::coordY_t VSyncStart = gamePkg::coordY_t'(`V_ACTIVE + `V_FRONT);
	localparam gamePkg::coordY_t VSyncEnd   = gamePkg::coordY_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);

	gamePkg::coordX_t hCount;    // Column 0..799
	gamePkg::coordY_t vCount;    // Line 0..524
	logic lineEnd;
	logic frameEnd;

	assign lineEnd  = (hCount == HLast);
	assign frameEnd = (vCount == VLast);

	always_ff @(posedge clock) begin
		if (rst) begin
			hCount <= '0;
			vCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
			if (frameEnd) begin
				vCount <= '0;    // Back to the top line
			end else begin
				vCount <= vCount + 10'd1;
			end
		end else begin
			hCount <= hCount + 10'd1;
		end
	end

	assign pos.x      = hCount;
	assign pos.y      = vCount;
	assign pos.active = (hCount < gamePkg::coordX_t'(`H_ACTIVE)) &&
	                    (vCount < gamePkg::coordY_t'(`V_ACTIVE));

	// Syncs are low inside their pulse window
	assign pos.hSync = ~((hCount >= HSyncStart) && (hCount < HSyncEnd));    // 656..751
	assign pos.vSync = ~((vCount >= VSyncStart) && (vCount < VSyncEnd));    // 490..491

endmodule

/* vga/spriteRenderer.sv */
// Colors each pixel from the two player squares, player 1 in front
// Descriptors are sampled once per frame at the start of the vsync line
`timescale 1ns/1ps
`include "gameIo_settings.svh"

module spriteRenderer (
	input  logic                 clock,
	input  logic                 rst,
	input  gamePkg::pixelPos_t   pos,
	input  gamePkg::playerDesc_t player1,
	input  gamePkg::playerDesc_t player2,
	output gamePkg::vgaOut_t     vga
);

	localparam gamePkg::coordY_t LoadLine = gamePkg::coordY_t'(`V_ACTIVE + `V_FRONT);

	gamePkg::playerDesc_t frameP1;    // Copy used for the whole frame
	gamePkg::playerDesc_t frameP2;
	gamePkg::color4_t pixelColor;
	logic frameLoad;
	logic inP1;
	logic inP2;

	// Square test widened by one bit so the far edge cannot wrap
	function automatic logic inSprite(
		input gamePkg::playerDesc_t p,
		input gamePkg::coordX_t     x,
		input gamePkg::coordY_t     y
	);
		logic [10:0] xEnd;
		logic [10:0] yEnd;
		xEnd = {1'b0, p.x} + 11'(`SPRITE_SIZE);
		yEnd = {1'b0, p.y} + 11'(`SPRITE_SIZE);
		return (x >= p.x) && ({1'b0, x} < xEnd) && (y >= p.y) && ({1'b0, y} < yEnd);
	endfunction

	assign frameLoad = (pos.y == LoadLine) && (pos.x == '0);    // Line 490, column 0
	assign inP1 = inSprite(frameP1, pos.x, pos.y);
	assign inP2 = inSprite(frameP2, pos.x, pos.y);

	always_comb begin
		if (!pos.active) begin
			pixelColor = '0;    // Blanking is black
		end else if (inP1) begin
			pixelColor = frameP1.color;
		end else if (inP2) begin
			pixelColor = frameP2.color;
		end else begin
			pixelColor = '0;    // Background
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			frameP1    <= '0;
			frameP2    <= '0;
			vga.hs     <= 1'b1;    // Syncs idle high
			vga.vs     <= 1'b1;
			vga.blankN <= 1'b0;
			vga.r      <= '0;
			vga.g      <= '0;
			vga.b      <= '0;
		end else begin
			if (frameLoad) begin
				frameP1 <= player1;
				frameP2 <= player2;
			end
			vga.hs     <= pos.hSync;    // One stage, aligned with color
			vga.vs     <= pos.vSync;
			vga.blankN <= pos.active;
			vga.r      <= {pixelColor[11:8], pixelColor[11:8]};    // Nibble repeated
			vga.g      <= {pixelColor[7:4], pixelColor[7:4]};
			vga.b      <= {pixelColor[3:0], pixelColor[3:0]};
		end
	end

endmodule

/* src/gameIoTop.sv */
// Top of the game I/O subsystem with APB in, controller pins, outputs and VGA
// Joins the bridge, the button synchronizer, the raster timing and the renderer
`timescale 1ns/1ps
`include "gameIo_settings.svh"

module gameIoTop (
	input  logic                      clock,
	input  logic                      rst,
	input  gamePkg::apbReq_t          apbIn,
	output gamePkg::apbRsp_t          apbOut,
	input  gamePkg::buttons_t         gpio,
	output logic [`GPIO_OUT_BITS-1:0] gpioOutput,
	output logic [`LED_BITS-1:0]      leds,
	output gamePkg::vgaOut_t          vga
);

	gamePkg::buttons_t level;           // Synchronized pins
	gamePkg::buttons_t sticky;          // Press flags
	logic clearSticky;
	gamePkg::playerDesc_t player1;
	gamePkg::playerDesc_t player2;
	gamePkg::pixelPos_t pos;            // Raster position

	controllerSync u_controllerSync (
		.clock       (clock),
		.rst         (rst),
		.pins        (gpio),
		.clearSticky (clearSticky),
		.level       (level),
		.sticky      (sticky)
	);

	mmioBridge u_mmioBridge (
		.clock       (clock),
		.rst         (rst),
		.apbIn       (apbIn),
		.apbOut      (apbOut),
		.level       (level),
		.sticky      (sticky),
		.clearSticky (clearSticky),
		.player1     (player1),
		.player2     (player2),
		.gpioOutput  (gpioOutput),
		.leds        (leds)
	);

	vgaTiming u_vgaTiming (
		.clock (clock),
		.rst   (rst),
		.pos   (pos)
	);

	spriteRenderer u_spriteRenderer (
		.clock   (clock),
		.rst     (rst),
		.pos     (pos),
		.player1 (player1),
		.player2 (player2),
		.vga     (vga)
	);

endmodule

/* bench/gameIo_properties.sv */
// Concurrent checks on the game I/O top level, attached with bind
`timescale 1ns/1ps
`include "gameIo_settings.svh"

module gameIoProperties (
	input logic             clock,
	input logic             rst,
	input gamePkg::apbReq_t apbIn,
	input gamePkg::apbRsp_t apbOut,
	input gamePkg::vgaOut_t vga
);

	int hsLowRun;    // Consecutive cycles with hs low

	always_ff @(posedge clock) begin
		if (rst) begin
			hsLowRun <= 0;
		end else if (!vga.hs) begin
			hsLowRun <= hsLowRun + 1;
		end else begin
			hsLowRun <= 0;
		end
	end

	readyInAccess: assert property (@(posedge clock) disable iff (rst)
		(apbIn.psel && apbIn.penable) |-> apbOut.pready)
		else $error("pready low in an APB access phase");

	errOnlyInAccess: assert property (@(posedge clock) disable iff (rst)
		!(apbIn.psel && apbIn.penable) |-> !apbOut.pslverr)
		else $error("pslverr high outside the access phase");

	blackWhenBlank: assert property (@(posedge clock) disable iff (rst)
		!vga.blankN |-> (vga.r == 8'h0 && vga.g == 8'h0 && vga.b == 8'h0))
		else $error("color present during blanking");

	hsPulseWidth: assert property (@(posedge clock) disable iff (rst)
		$rose(vga.hs) |-> (hsLowRun == `H_SYNC))
		else $error("hsync pulse width differs from the sync length");

endmodule

bind gameIoTop gameIoProperties u_gameIoProperties (.clock(clock), .rst(rst),
	.apbIn(apbIn), .apbOut(apbOut), .vga(vga));

/* bench/gameIoTb.sv */
// Testbench for the game I/O subsystem, acting as the APB master
// Checks memory, registers, errors, buttons and one rendered frame against a shadow model
`timescale 1ns/1ps
`include "gameIo_settings.svh"

module gameIoTb;

	logic clock;
	logic rst;
	gamePkg::apbReq_t apbIn;
	gamePkg::apbRsp_t apbOut;
	gamePkg::buttons_t gpio;
	logic [`GPIO_OUT_BITS-1:0] gpioOutput;
	logic [`LED_BITS-1:0] leds;
	gamePkg::vgaOut_t vga;

	gamePkg::word_t shadowMem [`RAM_WORDS];    // Scratch memory model
	gamePkg::playerDesc_t shP1;
	gamePkg::playerDesc_t shP2;
	gamePkg::word_t shGpio;
	gamePkg::word_t shLeds;
	gamePkg::buttons_t shLevel;
	gamePkg::buttons_t shSticky;
	gamePkg::busAddr_t written [$];            // Addresses of the memory test
	logic frameCheckOn = 1'b0;
	logic frameDone = 1'b0;
	int pixX = 0;                              // Rebuilt raster position
	int pixY = 0;

	gameIoTop u_gameIoTop (.clock(clock), .rst(rst), .apbIn(apbIn), .apbOut(apbOut),
		.gpio(gpio), .gpioOutput(gpioOutput), .leds(leds), .vga(vga));

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;    // 4 ns period
	end

	task automatic stopOnError(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkWord(input string name, input gamePkg::word_t exp,
			input gamePkg::word_t act);
		if (exp !== act) begin
			stopOnError($sformatf("error %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic checkButtons(input string name, input gamePkg::buttons_t exp,
			input gamePkg::buttons_t act);
		if (exp !== act) begin
			stopOnError($sformatf("error %s expected %h actual %h", name, exp, act));
		end
	endtask

	// Compares blank and color only
	task automatic checkPixel(input string name, input gamePkg::vgaOut_t exp,
			input gamePkg::vgaOut_t act);
		if ({exp.blankN, exp.r, exp.g, exp.b} !== {act.blankN, act.r, act.g, act.b}) begin
			stopOnError($sformatf("error %s expected %h actual %h", name,
				{exp.blankN, exp.r, exp.g, exp.b}, {act.blankN, act.r, act.g, act.b}));
		end
	endtask

	function automatic gamePkg::word_t expectedRead(input gamePkg::busAddr_t addr);
		if (addr < 12'h100) begin
			return shadowMem[addr[7:2]];
		end
		case (addr)
			`ADDR_PLAYER1:  return gamePkg::word_t'(shP1);
			`ADDR_PLAYER2:  return gamePkg::word_t'(shP2);
			`ADDR_BUTTONS:  return {shSticky, shLevel};    // Flags on top
			`ADDR_GPIO_OUT: return shGpio;
			`ADDR_LEDS:     return shLeds;
			default:        return '0;
		endcase
	endfunction

	task automatic modelWrite(input gamePkg::busAddr_t addr, input gamePkg::word_t data);
		if (addr < 12'h100) begin
			shadowMem[addr[7:2]] = data;
		end else if (addr == `ADDR_PLAYER1) begin
			shP1 = gamePkg::playerDesc_t'(data);
		end else if (addr == `ADDR_PLAYER2) begin
			shP2 = gamePkg::playerDesc_t'(data);
		end else if (addr == `ADDR_GPIO_OUT) begin
			shGpio = data & 32'h7;        // Three output pins
		end else if (addr == `ADDR_LEDS) begin
			shLeds = data & 32'hFFFF;
		end
	endtask

	function automatic logic insideSquare(input gamePkg::playerDesc_t p, input int x, input int y);
		return x >= int'(p.x) && x < int'(p.x) + `SPRITE_SIZE &&
			y >= int'(p.y) && y < int'(p.y) + `SPRITE_SIZE;
	endfunction

	function automatic gamePkg::vgaOut_t expectedPixel(input gamePkg::coordX_t x,
			input gamePkg::coordY_t y);
		gamePkg::vgaOut_t px;
		gamePkg::color4_t c;
		c = '0;
		if (insideSquare(shP2, int'(x), int'(y))) c = shP2.color;
		if (insideSquare(shP1, int'(x), int'(y))) c = shP1.color;    // Player 1 in front
		px.hs = 1'b1;
		px.vs = 1'b1;
		px.blankN = 1'b1;
		px.r = {c[11:8], c[11:8]};
		px.g = {c[7:4], c[7:4]};
		px.b = {c[3:0], c[3:0]};
		return px;
	endfunction

	task automatic apbTransfer(input logic write, input gamePkg::busAddr_t addr,
			input gamePkg::word_t wdata, output gamePkg::word_t rdata, output logic err);
		int waited;
		waited = 0;
		@(negedge clock);
		apbIn.psel    = 1'b1;    // Setup phase
		apbIn.penable = 1'b0;
		apbIn.pwrite  = write;
		apbIn.paddr   = addr;
		apbIn.pwdata  = wdata;
		@(negedge clock);
		apbIn.penable = 1'b1;    // Access phase
		@(posedge clock);
		while (!apbOut.pready) begin
			waited++;
			if (waited > 16) stopOnError("APB slave gave no pready within 16 cycles");
			@(posedge clock);
		end
		rdata = apbOut.prdata;
		err   = apbOut.pslverr;
		@(negedge clock);
		apbIn = '0;
	endtask

	task automatic apbWrite(input string name, input gamePkg::busAddr_t addr,
			input gamePkg::word_t data, input logic expErr);
		gamePkg::word_t rdata;
		logic err;
		apbTransfer(1'b1, addr, data, rdata, err);
		checkWord({name, " pslverr"}, gamePkg::word_t'(expErr), gamePkg::word_t'(err));
		if (!expErr) modelWrite(addr, data);
	endtask

	task automatic apbReadCheck(input string name, input gamePkg::busAddr_t addr,
			input logic expErr);
		gamePkg::word_t rdata;
		logic err;
		apbTransfer(1'b0, addr, '0, rdata, err);
		checkWord({name, " pslverr"}, gamePkg::word_t'(expErr), gamePkg::word_t'(err));
		if (!expErr) checkWord(name, expectedRead(addr), rdata);
	endtask

	task automatic readButtons(input string name);
		gamePkg::word_t rdata;
		logic err;
		apbTransfer(1'b0, `ADDR_BUTTONS, '0, rdata, err);
		checkWord({name, " pslverr"}, '0, gamePkg::word_t'(err));
		checkButtons({name, " sticky"}, shSticky, rdata[2*`BUTTON_COUNT-1:`BUTTON_COUNT]);
		checkButtons({name, " level"}, shLevel, rdata[`BUTTON_COUNT-1:0]);
		shSticky = '0;    // Cleared by the read
	endtask

	task automatic waitVs(input logic want);
		int waited;
		waited = 0;
		while (vga.vs !== want) begin
			waited++;
			if (waited > `H_TOTAL * `V_TOTAL) stopOnError("vsync did not toggle within a frame");
			@(negedge clock);
		end
	endtask

	// Frame checker, walks the active pixels of one frame
	always @(negedge clock) begin
		if (frameCheckOn && !frameDone) begin
			if (vga.blankN) begin
				checkPixel($sformatf("pixel %0d,%0d", pixX, pixY),
					expectedPixel(gamePkg::coordX_t'(pixX), gamePkg::coordY_t'(pixY)), vga);
				pixX = pixX + 1;
				if (pixX == `H_ACTIVE) begin
					pixX = 0;
					pixY = pixY + 1;
					if (pixY == `V_ACTIVE) frameDone = 1'b1;
				end
			end else begin
				checkPixel("blanked pixel", '0, vga);    // Must be black
			end
		end
	end

	initial begin
		gamePkg::busAddr_t addr;
		gamePkg::playerDesc_t p1;
		gamePkg::playerDesc_t p2;
		int waited;
		void'($urandom(22610));
		rst = 1'b1;
		apbIn = '0;
		gpio = '0;
		shP1 = '0;
		shP2 = '0;
		shGpio = '0;
		shLeds = '0;
		shLevel = '0;
		shSticky = '0;
		repeat (2) @(negedge clock);
		rst = 1'b0;

		for (int i = 0; i < 40; i++) begin
			addr = gamePkg::busAddr_t'($urandom_range(0, `RAM_WORDS - 1) * 4);
			apbWrite("memory write", addr, $urandom, 1'b0);
			written.push_back(addr);
		end
		foreach (written[i]) apbReadCheck("memory read", written[i], 1'b0);

		apbWrite("gpio write", `ADDR_GPIO_OUT, $urandom, 1'b0);
		apbWrite("led write", `ADDR_LEDS, $urandom, 1'b0);
		apbWrite("player1 write", `ADDR_PLAYER1, $urandom, 1'b0);
		apbWrite("player2 write", `ADDR_PLAYER2, $urandom, 1'b0);
		checkWord("gpio pins", shGpio, gamePkg::word_t'(gpioOutput));
		checkWord("led pins", shLeds, gamePkg::word_t'(leds));
		apbReadCheck("gpio read", `ADDR_GPIO_OUT, 1'b0);
		apbReadCheck("led read", `ADDR_LEDS, 1'b0);

		apbWrite("word zero write", 12'h000, $urandom, 1'b0);    // Low bits of 0x200 land here
		apbWrite("unmapped write", 12'h200, $urandom, 1'b1);
		apbWrite("unaligned write", written[0] | 12'h2, $urandom, 1'b1);
		apbWrite("button write", `ADDR_BUTTONS, $urandom, 1'b1);
		apbReadCheck("unmapped read", 12'h200, 1'b1);
		apbReadCheck("unaligned read", `ADDR_PLAYER1 + 12'h1, 1'b1);
		apbReadCheck("word zero after errors", 12'h000, 1'b0);
		apbReadCheck("memory after errors", written[0], 1'b0);
		apbReadCheck("player1 after errors", `ADDR_PLAYER1, 1'b0);
		apbReadCheck("player2 after errors", `ADDR_PLAYER2, 1'b0);
		apbReadCheck("gpio after errors", `ADDR_GPIO_OUT, 1'b0);
		apbReadCheck("led after errors", `ADDR_LEDS, 1'b0);

		gpio = gamePkg::buttons_t'($urandom) | gamePkg::buttons_t'(1);    // At least one press
		shLevel = gpio;
		shSticky = gpio;
		repeat (5) @(negedge clock);    // Past the 3-cycle flag latency
		readButtons("first button read");
		readButtons("second button read");

		p1.color = gamePkg::color4_t'($urandom);
		p1.y = gamePkg::coordY_t'($urandom_range(0, 452));
		p1.x = gamePkg::coordX_t'($urandom_range(0, 612));
		p2.color = gamePkg::color4_t'($urandom);
		p2.y = p1.y + gamePkg::coordY_t'($urandom_range(0, 12));    // Near player 1, may overlap
		p2.x = p1.x + gamePkg::coordX_t'($urandom_range(0, 12));
		apbWrite("player1 sprite", `ADDR_PLAYER1, gamePkg::word_t'(p1), 1'b0);
		apbWrite("player2 sprite", `ADDR_PLAYER2, gamePkg::word_t'(p2), 1'b0);
		waitVs(1'b1);
		waitVs(1'b0);
		waitVs(1'b1);    // Descriptors latched in that pulse
		frameCheckOn = 1'b1;
		waited = 0;
		while (!frameDone) begin
			waited++;
			if (waited > `H_TOTAL * `V_TOTAL) stopOnError("frame check did not finish in a frame");
			@(negedge clock);
		end

		$display("Regression passed");
		$finish;
	end

endmodule

/* Makefile */
# Verilator build and run of the game I/O testbench
TOP := gameIoTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -Mdir obj_dir -o $(TOP)

# Pass only when the run prints the pass message
run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

/* all.f */
+incdir+common
common/gamePkg.sv
mmio/controllerSync.sv
mmio/mmioBridge.sv
vga/vgaTiming.sv
vga/spriteRenderer.sv
src/gameIoTop.sv
bench/gameIo_properties.sv
bench/gameIoTb.sv
